// File: logic/xdma_pkg.sv
// shared xdma types; mailbox windows assume MMIO size a multiple of 4 KB, only two slots used
package xdma_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int AddrWidth = 48;
  localparam int DataWidth = 64;
  localparam int LenWidth  = 8;

  // byte address on the wide port
  typedef logic [AddrWidth-1:0] addr_t;
  // one write beat, 8 bytes
  typedef logic [DataWidth-1:0] data_t;
  // beats per transfer, 1..255
  typedef logic [LenWidth-1:0]  len_t;

  // ------------------------------
  // mailbox slots
  // ------------------------------
  // index picks the window counted down from the region end
  typedef enum logic {
    MBOX_DATA = 1'b0,
    MBOX_CFG  = 1'b1
  } slot_e;

  // sender arbitration states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_CFG,
    CTRL_DATA
  } ctrl_state_e;

  // distance of a slot's window below the region end
  // each window is a quarter of the MMIO area
  function automatic addr_t mbox_offset(input int unsigned mmio_size_kb, input slot_e slot);
    addr_t win_size;
    win_size = addr_t'(mmio_size_kb / 4) * 48'd1024;
    return (addr_t'(slot) + 48'd1) * win_size;
  endfunction

endpackage

// File: logic/xdma_write_if.sv
// one request in flight at a time; req_valid is a single-cycle pulse, done marks the last beat
`timescale 1ns/1ns
interface xdma_write_if ();
  import xdma_pkg::*;

  // request, sampled by the issuer on the grant edge
  logic  req_valid;
  addr_t req_addr;
  len_t  req_len;

  // beat stream from the granted source
  logic  beat_valid;
  data_t beat_data;
  logic  beat_ready;

  // last beat handshake
  logic  done;

  modport ctrl (
    output req_valid, req_addr, req_len,
    output beat_valid, beat_data,
    input  beat_ready, done
  );

  modport issuer (
    input  req_valid, req_addr, req_len,
    input  beat_valid, beat_data,
    output beat_ready, done
  );

endinterface

// File: logic/xdma_mailbox_map.sv
// purely combinational; ClusterAddressSpace must be a power of two, peers below ClusterBaseAddr wrap
`timescale 1ns/1ns
module xdma_mailbox_map #(
  parameter xdma_pkg::addr_t ClusterBaseAddr     = 48'h0000_1000_0000,
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0000_0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h0000_8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h0001_0000_0000,
  parameter int unsigned     MmioSizeKb          = 16
) (
  input  xdma_pkg::addr_t peer_addr_i,
  input  xdma_pkg::slot_e slot_i,
  output xdma_pkg::addr_t mbox_addr_o
);
  import xdma_pkg::*;

  localparam int unsigned ShiftBits = $clog2(ClusterAddressSpace);

  addr_t cluster_idx;
  addr_t cluster_end;
  addr_t region_end;
  logic  in_main_mem;

  // ------------------------------
  // region end of the peer
  // ------------------------------
  // everything from MainMemBaseAddr up counts as main memory
  assign in_main_mem = (peer_addr_i >= MainMemBaseAddr);

  // cluster number relative to the first cluster
  assign cluster_idx = (peer_addr_i - ClusterBaseAddr) >> ShiftBits;

  // first byte past that cluster
  assign cluster_end = ClusterBaseAddr + ((cluster_idx + 48'd1) << ShiftBits);

  assign region_end = in_main_mem ? MainMemEndAddr : cluster_end;

  // ------------------------------
  // mailbox address
  // ------------------------------
  // slot windows sit at the top of the region
  assign mbox_addr_o = region_end - mbox_offset(MmioSizeKb, slot_i);

endmodule

// File: logic/xdma_req_ctrl.sv
// fixed priority, cfg over data; a data transfer starts on to_remote_data_start_i, not on valid
`timescale 1ns/1ns
module xdma_req_ctrl #(
  parameter xdma_pkg::addr_t ClusterBaseAddr     = 48'h0000_1000_0000,
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0000_0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h0000_8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h0001_0000_0000,
  parameter int unsigned     MmioSizeKb          = 16
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // cfg source, one beat
  input  xdma_pkg::data_t to_remote_cfg_i,
  input  logic            to_remote_cfg_valid_i,
  input  logic            to_remote_cfg_dma_type_i,
  input  xdma_pkg::addr_t to_remote_cfg_reader_addr_i,
  input  xdma_pkg::addr_t to_remote_cfg_writer_addr_i,
  output logic            to_remote_cfg_ready_o,
  // data source, multi beat
  input  xdma_pkg::data_t to_remote_data_i,
  input  logic            to_remote_data_valid_i,
  input  xdma_pkg::addr_t to_remote_data_dst_addr_i,
  input  xdma_pkg::len_t  to_remote_data_len_i,
  input  logic            to_remote_data_start_i,
  output logic            to_remote_data_ready_o,
  // towards the issuer
  xdma_write_if.ctrl      wr
);
  import xdma_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        sel_cfg;
  addr_t       cfg_peer;
  addr_t       peer_addr;
  slot_e       slot;

  // ------------------------------
  // source select and mapping
  // ------------------------------
  // read: remote holds the data, write: remote receives it
  assign cfg_peer = to_remote_cfg_dma_type_i ? to_remote_cfg_writer_addr_i
                                             : to_remote_cfg_reader_addr_i;

  // cfg wins whenever it is pending at idle
  assign sel_cfg   = to_remote_cfg_valid_i;
  assign peer_addr = sel_cfg ? cfg_peer : to_remote_data_dst_addr_i;
  assign slot      = sel_cfg ? MBOX_CFG : MBOX_DATA;

  xdma_mailbox_map #(
    .ClusterBaseAddr    (ClusterBaseAddr),
    .ClusterAddressSpace(ClusterAddressSpace),
    .MainMemBaseAddr    (MainMemBaseAddr),
    .MainMemEndAddr     (MainMemEndAddr),
    .MmioSizeKb         (MmioSizeKb)
  ) i_mailbox_map (
    .peer_addr_i(peer_addr),
    .slot_i     (slot),
    .mbox_addr_o(wr.req_addr)
  );

  // request pulses only in idle, issuer samples it on the grant edge
  assign wr.req_valid = (state_q == CTRL_IDLE) && (to_remote_cfg_valid_i || to_remote_data_start_i);
  assign wr.req_len   = sel_cfg ? 8'd1 : to_remote_data_len_i;

  // ------------------------------
  // state machine
  // ------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CTRL_IDLE: begin
        if (to_remote_cfg_valid_i) begin
          state_d = CTRL_CFG;
        end else if (to_remote_data_start_i) begin
          state_d = CTRL_DATA;
        end
      end
      // locked on the source until its last beat
      default: begin
        if (wr.done) begin
          state_d = CTRL_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // beat steering
  // ------------------------------
  always_comb begin
    wr.beat_valid          = 1'b0;
    wr.beat_data           = to_remote_cfg_i;
    to_remote_cfg_ready_o  = 1'b0;
    to_remote_data_ready_o = 1'b0;
    unique case (state_q)
      CTRL_CFG: begin
        wr.beat_valid         = to_remote_cfg_valid_i;
        to_remote_cfg_ready_o = wr.beat_ready;
      end
      CTRL_DATA: begin
        wr.beat_valid          = to_remote_data_valid_i;
        wr.beat_data           = to_remote_data_i;
        to_remote_data_ready_o = wr.beat_ready;
      end
      // idle, nothing moves
      default: begin
      end
    endcase
  end

  // issuer only opens a beat phase after a grant, never while idle
  a_idle_no_beat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == CTRL_IDLE) |-> !wr.beat_ready);

endmodule

// File: logic/xdma_aw_w_issuer.sv
// no write response or IDs; beats wait until the address is accepted, no beat buffering
`timescale 1ns/1ns
module xdma_aw_w_issuer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  xdma_write_if.issuer    wr,
  // address channel
  output logic            aw_valid_o,
  output xdma_pkg::addr_t aw_addr_o,
  output xdma_pkg::len_t  aw_len_o,
  input  logic            aw_ready_i,
  // write channel
  output logic            w_valid_o,
  output xdma_pkg::data_t w_data_o,
  output logic            w_last_o,
  input  logic            w_ready_i
);
  import xdma_pkg::*;

  logic  aw_valid_q;
  logic  w_active_q;
  addr_t addr_q;
  len_t  len_q;
  len_t  cnt_q;
  logic  w_hs;

  // ------------------------------
  // control flags
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_valid_q <= 1'b0;
      w_active_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      if (wr.req_valid) begin
        aw_valid_q <= 1'b1;
        cnt_q      <= '0;
      end else if (aw_valid_q && aw_ready_i) begin
        // address taken, open the beat phase
        aw_valid_q <= 1'b0;
        w_active_q <= 1'b1;
      end
      if (w_hs) begin
        cnt_q <= cnt_q + 8'd1;
        if (w_last_o) begin
          w_active_q <= 1'b0;
        end
      end
    end
  end

  // request payload, held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (wr.req_valid) begin
      addr_q <= wr.req_addr;
      len_q  <= wr.req_len - 8'd1;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------
  assign aw_valid_o = aw_valid_q;
  assign aw_addr_o  = addr_q;
  // axi style length, beats minus one
  assign aw_len_o   = len_q;

  // beats pass straight through
  assign w_valid_o     = w_active_q && wr.beat_valid;
  assign w_data_o      = wr.beat_data;
  assign w_last_o      = w_valid_o && (cnt_q == len_q);
  assign wr.beat_ready = w_active_q && w_ready_i;

  assign w_hs    = w_valid_o && w_ready_i;
  assign wr.done = w_hs && w_last_o;

  a_aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));

  // beat phase closes on the last beat, count never runs past the length
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_valid_o |-> cnt_q <= len_q);

endmodule

// File: logic/xdma_receive_demux.sv
// single outstanding write; beats outside both mailbox windows are accepted and dropped
`timescale 1ns/1ns
module xdma_receive_demux #(
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0000_0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h0000_8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h0001_0000_0000,
  parameter int unsigned     MmioSizeKb          = 16
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  xdma_pkg::addr_t cluster_base_addr_i,
  // incoming address
  input  logic            aw_valid_i,
  input  xdma_pkg::addr_t aw_addr_i,
  output logic            aw_ready_o,
  // incoming beats
  input  logic            w_valid_i,
  input  xdma_pkg::data_t w_data_i,
  input  logic            w_last_i,
  output logic            w_ready_o,
  // local outputs
  output xdma_pkg::data_t from_remote_data_o,
  output logic            from_remote_data_valid_o,
  input  logic            from_remote_data_ready_i,
  output xdma_pkg::data_t from_remote_cfg_o,
  output logic            from_remote_cfg_valid_o,
  input  logic            from_remote_cfg_ready_i
);
  import xdma_pkg::*;

  // slot 0 sits one window below the end, so its offset is the window size
  localparam addr_t WinSize = mbox_offset(MmioSizeKb, MBOX_DATA);

  logic  busy_q;
  addr_t addr_q;
  addr_t local_end;
  addr_t data_lo;
  addr_t cfg_lo;
  logic  hit_data;
  logic  hit_cfg;

  function automatic logic in_window(input addr_t addr, input addr_t lo);
    return (addr >= lo) && (addr < lo + WinSize);
  endfunction

  // ------------------------------
  // address phase
  // ------------------------------
  assign aw_ready_o = !busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (aw_valid_i && aw_ready_o) begin
      busy_q <= 1'b1;
    end else if (w_valid_i && w_ready_o && w_last_i) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      addr_q <= aw_addr_i;
    end
  end

  // ------------------------------
  // local window decode
  // ------------------------------
  // main memory ends at MainMemEndAddr, a cluster one space above its base
  assign local_end = (cluster_base_addr_i == MainMemBaseAddr) ? MainMemEndAddr
                                                              : cluster_base_addr_i + ClusterAddressSpace;
  assign data_lo   = local_end - mbox_offset(MmioSizeKb, MBOX_DATA);
  assign cfg_lo    = local_end - mbox_offset(MmioSizeKb, MBOX_CFG);
  assign hit_data  = busy_q && in_window(addr_q, data_lo);
  assign hit_cfg   = busy_q && in_window(addr_q, cfg_lo);

  // ------------------------------
  // beat routing
  // ------------------------------
  assign from_remote_data_o       = w_data_i;
  assign from_remote_data_valid_o = hit_data && w_valid_i;
  assign from_remote_cfg_o        = w_data_i;
  assign from_remote_cfg_valid_o  = hit_cfg && w_valid_i;

  // a miss drains at full rate
  always_comb begin
    if (!busy_q) begin
      w_ready_o = 1'b0;
    end else if (hit_data) begin
      w_ready_o = from_remote_data_ready_i;
    end else if (hit_cfg) begin
      w_ready_o = from_remote_cfg_ready_i;
    end else begin
      w_ready_o = 1'b1;
    end
  end

  a_one_output: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(from_remote_data_valid_o && from_remote_cfg_valid_o));

endmodule

// File: logic/xdma_adapter_top.sv
// aw/w only, no read or response channels; sender and receiver sides share no state
`timescale 1ns/1ns
module xdma_adapter_top #(
  parameter xdma_pkg::addr_t ClusterBaseAddr     = 48'h0000_1000_0000,
  parameter xdma_pkg::addr_t ClusterAddressSpace = 48'h0000_0010_0000,
  parameter xdma_pkg::addr_t MainMemBaseAddr     = 48'h0000_8000_0000,
  parameter xdma_pkg::addr_t MainMemEndAddr      = 48'h0001_0000_0000,
  parameter int unsigned     MmioSizeKb          = 16
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  xdma_pkg::addr_t cluster_base_addr_i,
  // ------------------------------
  // sender side
  // ------------------------------
  input  xdma_pkg::data_t to_remote_cfg_i,
  input  logic            to_remote_cfg_valid_i,
  input  logic            to_remote_cfg_dma_type_i,
  input  xdma_pkg::addr_t to_remote_cfg_reader_addr_i,
  input  xdma_pkg::addr_t to_remote_cfg_writer_addr_i,
  output logic            to_remote_cfg_ready_o,
  input  xdma_pkg::data_t to_remote_data_i,
  input  logic            to_remote_data_valid_i,
  input  xdma_pkg::addr_t to_remote_data_dst_addr_i,
  input  xdma_pkg::len_t  to_remote_data_len_i,
  input  logic            to_remote_data_start_i,
  output logic            to_remote_data_ready_o,
  // outgoing aw/w
  output logic            aw_valid_o,
  output xdma_pkg::addr_t aw_addr_o,
  output xdma_pkg::len_t  aw_len_o,
  input  logic            aw_ready_i,
  output logic            w_valid_o,
  output xdma_pkg::data_t w_data_o,
  output logic            w_last_o,
  input  logic            w_ready_i,
  // ------------------------------
  // receiver side
  // ------------------------------
  input  logic            aw_valid_i,
  input  xdma_pkg::addr_t aw_addr_i,
  output logic            aw_ready_o,
  input  logic            w_valid_i,
  input  xdma_pkg::data_t w_data_i,
  input  logic            w_last_i,
  output logic            w_ready_o,
  output xdma_pkg::data_t from_remote_data_o,
  output logic            from_remote_data_valid_o,
  input  logic            from_remote_data_ready_i,
  output xdma_pkg::data_t from_remote_cfg_o,
  output logic            from_remote_cfg_valid_o,
  input  logic            from_remote_cfg_ready_i
);

  // selected request between arbiter and issuer
  xdma_write_if wr ();

  xdma_req_ctrl #(
    .ClusterBaseAddr    (ClusterBaseAddr),
    .ClusterAddressSpace(ClusterAddressSpace),
    .MainMemBaseAddr    (MainMemBaseAddr),
    .MainMemEndAddr     (MainMemEndAddr),
    .MmioSizeKb         (MmioSizeKb)
  ) i_req_ctrl (
    .clk_i                      (clk_i),
    .arst_n_i                   (arst_n_i),
    .to_remote_cfg_i            (to_remote_cfg_i),
    .to_remote_cfg_valid_i      (to_remote_cfg_valid_i),
    .to_remote_cfg_dma_type_i   (to_remote_cfg_dma_type_i),
    .to_remote_cfg_reader_addr_i(to_remote_cfg_reader_addr_i),
    .to_remote_cfg_writer_addr_i(to_remote_cfg_writer_addr_i),
    .to_remote_cfg_ready_o      (to_remote_cfg_ready_o),
    .to_remote_data_i           (to_remote_data_i),
    .to_remote_data_valid_i     (to_remote_data_valid_i),
    .to_remote_data_dst_addr_i  (to_remote_data_dst_addr_i),
    .to_remote_data_len_i       (to_remote_data_len_i),
    .to_remote_data_start_i     (to_remote_data_start_i),
    .to_remote_data_ready_o     (to_remote_data_ready_o),
    .wr                         (wr.ctrl)
  );

  xdma_aw_w_issuer i_aw_w_issuer (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wr        (wr.issuer),
    .aw_valid_o(aw_valid_o),
    .aw_addr_o (aw_addr_o),
    .aw_len_o  (aw_len_o),
    .aw_ready_i(aw_ready_i),
    .w_valid_o (w_valid_o),
    .w_data_o  (w_data_o),
    .w_last_o  (w_last_o),
    .w_ready_i (w_ready_i)
  );

  xdma_receive_demux #(
    .ClusterAddressSpace(ClusterAddressSpace),
    .MainMemBaseAddr    (MainMemBaseAddr),
    .MainMemEndAddr     (MainMemEndAddr),
    .MmioSizeKb         (MmioSizeKb)
  ) i_receive_demux (
    .clk_i                   (clk_i),
    .arst_n_i                (arst_n_i),
    .cluster_base_addr_i     (cluster_base_addr_i),
    .aw_valid_i              (aw_valid_i),
    .aw_addr_i               (aw_addr_i),
    .aw_ready_o              (aw_ready_o),
    .w_valid_i               (w_valid_i),
    .w_data_i                (w_data_i),
    .w_last_i                (w_last_i),
    .w_ready_o               (w_ready_o),
    .from_remote_data_o      (from_remote_data_o),
    .from_remote_data_valid_o(from_remote_data_valid_o),
    .from_remote_data_ready_i(from_remote_data_ready_i),
    .from_remote_cfg_o       (from_remote_cfg_o),
    .from_remote_cfg_valid_o (from_remote_cfg_valid_o),
    .from_remote_cfg_ready_i (from_remote_cfg_ready_i)
  );

endmodule

// File: dv/xdma_tb_clk.sv
// free running clock from time zero; reset is released on a falling edge, never re-asserted
`timescale 1ns/1ns
module xdma_tb_clk #(
  parameter int unsigned PeriodNs    = 10,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  // half period toggle
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // hold reset, let go away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: dv/xdma_tb.sv
// inputs change on falling edges, outputs are sampled on rising edges; one test runs at a time
`timescale 1ns/1ns
module xdma_tb;
  import xdma_pkg::*;

  localparam addr_t       ClusterBase    = 48'h0000_1000_0000;
  localparam addr_t       ClusterSpace   = 48'h0000_0010_0000;
  localparam addr_t       MainMemBase    = 48'h0000_8000_0000;
  localparam addr_t       MainMemEnd     = 48'h0001_0000_0000;
  localparam int unsigned MmioSizeKb     = 16;
  localparam int          NumCfg         = 20;
  localparam int          NumData        = 20;
  localparam int          NumArb         = 10;
  localparam int          NumRecv        = 40;
  // an arbitration round carries two transfers
  localparam int          NumTransfers   = NumCfg + NumData + 2 * NumArb + NumRecv;
  localparam int          WatchdogCycles = NumTransfers * 255 * 8 + 10;

  logic clk;
  logic arst_n;
  logic [31:0] lfsr_q;

  addr_t cluster_base_addr_i;
  data_t to_remote_cfg_i, to_remote_data_i, w_data_o, w_data_i;
  data_t from_remote_data_o, from_remote_cfg_o;
  addr_t to_remote_cfg_reader_addr_i, to_remote_cfg_writer_addr_i, to_remote_data_dst_addr_i;
  addr_t aw_addr_o, aw_addr_i;
  len_t  to_remote_data_len_i, aw_len_o;
  logic  to_remote_cfg_valid_i, to_remote_cfg_dma_type_i, to_remote_cfg_ready_o;
  logic  to_remote_data_valid_i, to_remote_data_start_i, to_remote_data_ready_o;
  logic  aw_valid_o, aw_ready_i, w_valid_o, w_last_o, w_ready_i;
  logic  aw_valid_i, aw_ready_o, w_valid_i, w_last_i, w_ready_o;
  logic  from_remote_data_valid_o, from_remote_data_ready_i;
  logic  from_remote_cfg_valid_o, from_remote_cfg_ready_i;

  // expected sender traffic, in order
  addr_t exp_addr[$];
  len_t  exp_len[$];
  data_t exp_beat[$];
  logic  exp_last[$];

  xdma_tb_clk #(.PeriodNs(10), .ResetCycles(10)) i_clk (.clk_o(clk), .arst_n_o(arst_n));

  xdma_adapter_top #(
    .ClusterBaseAddr(ClusterBase), .ClusterAddressSpace(ClusterSpace),
    .MainMemBaseAddr(MainMemBase), .MainMemEndAddr(MainMemEnd), .MmioSizeKb(MmioSizeKb)
  ) DUT (.*, .clk_i(clk), .arst_n_i(arst_n));

  // ------------------------------
  // random source and model
  // ------------------------------
  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // half main memory, half some cluster above the first one
  function automatic addr_t random_peer();
    addr_t idx;
    if (logic'(rand_bits(1))) begin
      return MainMemBase + addr_t'(rand_bits(31));
    end
    idx = addr_t'(rand_bits(10));
    return ClusterBase + idx * ClusterSpace + addr_t'(rand_bits(20));
  endfunction

  // region end minus (slot + 1) quarter windows of the mmio area
  function automatic addr_t model_mbox(input addr_t peer, input logic slot_cfg);
    addr_t region_end;
    addr_t win;
    win = addr_t'(MmioSizeKb / 4) * addr_t'(1024);
    if (peer >= MainMemBase) begin
      region_end = MainMemEnd;
    end else begin
      region_end = ClusterBase + ((peer - ClusterBase) / ClusterSpace + 48'd1) * ClusterSpace;
    end
    return slot_cfg ? region_end - win - win : region_end - win;
  endfunction

  // ------------------------------
  // checks
  // ------------------------------
  task automatic fail_run(input string msg);
    $display("SIMULATION FAILED");
    $display("%s", msg);
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_len(input string name, input len_t exp, input len_t act);
    if (exp !== act) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  // idle: nothing valid, receiver open for an address
  task automatic check_idle_outputs();
    check_bit("aw_valid_o", 1'b0, aw_valid_o);
    check_bit("w_valid_o", 1'b0, w_valid_o);
    check_bit("to_remote_cfg_ready_o", 1'b0, to_remote_cfg_ready_o);
    check_bit("to_remote_data_ready_o", 1'b0, to_remote_data_ready_o);
    check_bit("w_ready_o", 1'b0, w_ready_o);
    check_bit("from_remote_data_valid_o", 1'b0, from_remote_data_valid_o);
    check_bit("from_remote_cfg_valid_o", 1'b0, from_remote_cfg_valid_o);
    check_bit("aw_ready_o", 1'b1, aw_ready_o);
  endtask

  // ------------------------------
  // sender side
  // ------------------------------
  // starts and ends on a falling edge, cfg first when both are requested
  task automatic send_transfer(input logic do_cfg, input logic do_data);
    data_t data_q[$];
    logic  kind_q[$];
    data_t beat;
    addr_t peer;
    int    len;
    int    i;
    int    aw_left;
    int    owner;
    logic  cfg_hs;
    logic  data_hs;
    logic  last;
    aw_left = 0;
    owner   = 0;
    cfg_hs  = 1'b0;
    data_hs = 1'b0;
    if (do_cfg) begin
      to_remote_cfg_i             = data_t'(rand_bits(64));
      to_remote_cfg_dma_type_i    = logic'(rand_bits(1));
      to_remote_cfg_reader_addr_i = random_peer();
      to_remote_cfg_writer_addr_i = random_peer();
      to_remote_cfg_valid_i       = 1'b1;
      // write goes to the writer, read to the reader
      peer = to_remote_cfg_dma_type_i ? to_remote_cfg_writer_addr_i : to_remote_cfg_reader_addr_i;
      exp_addr.push_back(model_mbox(peer, 1'b1));
      exp_len.push_back(len_t'(0));
      exp_beat.push_back(to_remote_cfg_i);
      exp_last.push_back(1'b1);
      kind_q.push_back(1'b1);
      aw_left++;
    end
    if (do_data) begin
      len = 1 + int'(rand_bits(5));
      to_remote_data_dst_addr_i = random_peer();
      to_remote_data_len_i      = len_t'(len);
      to_remote_data_start_i    = 1'b1;
      exp_addr.push_back(model_mbox(to_remote_data_dst_addr_i, 1'b0));
      exp_len.push_back(len_t'(len - 1));
      for (i = 0; i < len; i++) begin
        beat = data_t'(rand_bits(64));
        data_q.push_back(beat);
        exp_beat.push_back(beat);
        exp_last.push_back(i == len - 1);
      end
      kind_q.push_back(1'b0);
      aw_left++;
    end
    while (aw_left > 0 || exp_beat.size() > 0) begin
      aw_ready_i = logic'(rand_bits(1));
      w_ready_i  = logic'(rand_bits(1));
      if (cfg_hs) to_remote_cfg_valid_i = 1'b0;
      // data request seen on the port, so its grant has happened
      if (to_remote_data_start_i && aw_valid_o && !to_remote_cfg_valid_i) begin
        to_remote_data_start_i = 1'b0;
      end
      if (data_hs) to_remote_data_valid_i = 1'b0;
      if (!to_remote_data_valid_i && data_q.size() > 0 && logic'(rand_bits(1))) begin
        to_remote_data_i       = data_q.pop_front();
        to_remote_data_valid_i = 1'b1;
      end
      @(posedge clk);
      // only the source whose address went out sees w_ready_i
      check_bit("to_remote_cfg_ready_o", owner == 1 && w_ready_i, to_remote_cfg_ready_o);
      check_bit("to_remote_data_ready_o", owner == 2 && w_ready_i, to_remote_data_ready_o);
      if (aw_valid_o) begin
        if (exp_addr.size() == 0) fail_run("address request issued with no transfer pending");
        check_addr("aw_addr_o", exp_addr[0], aw_addr_o);
        check_len("aw_len_o", exp_len[0], aw_len_o);
        if (aw_ready_i) begin
          void'(exp_addr.pop_front());
          void'(exp_len.pop_front());
          owner = kind_q.pop_front() ? 1 : 2;
          aw_left--;
        end
      end
      if (w_valid_o && w_ready_i) begin
        if (exp_beat.size() == 0) fail_run("write beat sent with no beat expected");
        check_data("w_data_o", exp_beat.pop_front(), w_data_o);
        last = exp_last.pop_front();
        check_bit("w_last_o", last, w_last_o);
        if (last) owner = 0;
      end
      cfg_hs  = cfg_hs || (to_remote_cfg_valid_i && to_remote_cfg_ready_o);
      data_hs = to_remote_data_valid_i && to_remote_data_ready_o;
      @(negedge clk);
    end
    to_remote_cfg_valid_i  = 1'b0;
    to_remote_data_valid_i = 1'b0;
    to_remote_data_start_i = 1'b0;
  endtask

  // ------------------------------
  // receiver side
  // ------------------------------
  // target 0 data window, 1 cfg window, 2 the quarter below both
  task automatic receive_write();
    data_t beats[$];
    addr_t local_end;
    addr_t win;
    int    target;
    int    len;
    int    idx;
    int    next;
    int    i;
    logic  hs;
    logic  exp_ready;
    target = int'(rand_bits(2)) % 3;
    len    = 1 + int'(rand_bits(3));
    win    = addr_t'(MmioSizeKb / 4) * addr_t'(1024);
    if (rand_bits(2) == 64'd0) begin
      cluster_base_addr_i = MainMemBase;
    end else begin
      cluster_base_addr_i = ClusterBase + addr_t'(rand_bits(10)) * ClusterSpace;
    end
    local_end = (cluster_base_addr_i == MainMemBase) ? MainMemEnd
                                                     : cluster_base_addr_i + ClusterSpace;
    aw_addr_i = local_end - win;
    for (i = 0; i < target; i++) aw_addr_i = aw_addr_i - win;
    aw_addr_i = aw_addr_i + (addr_t'(rand_bits(9)) << 3);
    for (i = 0; i < len; i++) beats.push_back(data_t'(rand_bits(64)));
    aw_valid_i = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(posedge clk);
      hs = aw_ready_o;
      @(negedge clk);
    end
    aw_valid_i = 1'b0;
    idx  = 0;
    next = 0;
    hs   = 1'b0;
    while (idx < len) begin
      if (hs) w_valid_i = 1'b0;
      if (!w_valid_i && next < len && logic'(rand_bits(1))) begin
        w_data_i  = beats[next];
        w_last_i  = (next == len - 1);
        w_valid_i = 1'b1;
        next++;
      end
      from_remote_data_ready_i = logic'(rand_bits(1));
      from_remote_cfg_ready_i  = logic'(rand_bits(1));
      // a hit follows its output's ready, misses still drain
      case (target)
        0:       exp_ready = from_remote_data_ready_i;
        1:       exp_ready = from_remote_cfg_ready_i;
        default: exp_ready = 1'b1;
      endcase
      @(posedge clk);
      // no new address until the last beat is taken
      check_bit("aw_ready_o", 1'b0, aw_ready_o);
      check_bit("from_remote_data_valid_o", w_valid_i && target == 0, from_remote_data_valid_o);
      check_bit("from_remote_cfg_valid_o", w_valid_i && target == 1, from_remote_cfg_valid_o);
      check_bit("w_ready_o", exp_ready, w_ready_o);
      hs = w_valid_i && w_ready_o;
      if (hs) begin
        if (target == 0) check_data("from_remote_data_o", beats[idx], from_remote_data_o);
        if (target == 1) check_data("from_remote_cfg_o", beats[idx], from_remote_cfg_o);
        idx++;
      end
      @(negedge clk);
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    lfsr_q = 32'd24;
    {cluster_base_addr_i, to_remote_cfg_i, to_remote_data_i, w_data_i} = '0;
    {to_remote_cfg_reader_addr_i, to_remote_cfg_writer_addr_i} = '0;
    {to_remote_data_dst_addr_i, aw_addr_i, to_remote_data_len_i} = '0;
    {to_remote_cfg_valid_i, to_remote_cfg_dma_type_i, to_remote_data_valid_i} = '0;
    {to_remote_data_start_i, aw_ready_i, w_ready_i, aw_valid_i, w_valid_i, w_last_i} = '0;
    {from_remote_data_ready_i, from_remote_cfg_ready_i} = '0;
    // inside reset
    repeat (3) begin
      @(negedge clk);
      check_idle_outputs();
    end
    wait (arst_n);
    @(negedge clk);
    check_idle_outputs();
    repeat (NumCfg) send_transfer(1'b1, 1'b0);
    repeat (NumData) send_transfer(1'b0, 1'b1);
    repeat (NumArb) send_transfer(1'b1, 1'b1);
    repeat (NumRecv) receive_write();
    @(negedge clk);
    check_idle_outputs();
    $display("SIMULATION PASSED");
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    fail_run("timeout, the tests did not finish within the cycle limit");
  end

endmodule

// File: flist.f
logic/xdma_pkg.sv
logic/xdma_write_if.sv
logic/xdma_mailbox_map.sv
logic/xdma_req_ctrl.sv
logic/xdma_aw_w_issuer.sv
logic/xdma_receive_demux.sv
logic/xdma_adapter_top.sv
dv/xdma_tb_clk.sv
dv/xdma_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the xdma testbench with Verilator; exit status is the simulation result
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module xdma_tb -f flist.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit "$status"
fi

./obj_dir/Vxdma_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
